//--- design/icache_pkg.sv
// ====================================================================
// Types and geometry shared by the two-bank instruction cache
// Lines are 16 bytes and the banks alternate on address bit 4
// The cache must stay smaller than a page so that index bits are untranslated
// ====================================================================
package icache_pkg;

	// Address split: [31:9] tag, [8:5] set index, [4] bank, [3:0] byte
	localparam int ADDR_W = 32;
	localparam int LINE_W = 128;
	localparam int LOBIT = 4;
	localparam int IDX_LO = LOBIT + 1;
	localparam int IDX_W = 4;
	localparam int TAG_LO = IDX_LO + IDX_W;
	localparam int TAG_W = ADDR_W - TAG_LO;

	// Per-bank organisation
	localparam int SETS = 1 << IDX_W;
	localparam int WAYS = 2;
	localparam int WAY_W = 1;
	localparam int BANKS = 2;

	// Line RAM word address is the way on top of the set index
	localparam int RAM_ADR_W = WAY_W + IDX_W;

	// Tag and index together form the address of a line within one bank
	localparam int SET_ADR_W = TAG_W + IDX_W;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [IDX_W-1:0] index_t;
	typedef logic [WAY_W-1:0] way_t;
	typedef logic [5:0] cid_t;

	// Snoops carrying this identity came from this cache and are dropped
	localparam cid_t CID = 6'd2;

	// Software invalidation request
	// Code 3 is not defined
	typedef enum logic [1:0] {
		INV_NONE = 2'd0,
		INV_LINE = 2'd1,
		INV_ALL = 2'd2
	} inv_op_t;

endpackage

//--- design/icache_line_ram.sv
// ====================================================================
// Line data memory with one write port and one registered read port
// A read of the word written at the same edge returns the old data
// ====================================================================
`timescale 1ns/1ps

module icache_line_ram (
	input  logic                              clk,
	input  logic                              wr_i,
	input  logic [icache_pkg::RAM_ADR_W-1:0] wadr_i,
	input  logic [icache_pkg::RAM_ADR_W-1:0] rd_adr_i,
	input  icache_pkg::line_t                 wdata_i,
	output icache_pkg::line_t                 rdata_o
);

	// One word per way and set, addressed as {way, index}
	icache_pkg::line_t mem [icache_pkg::WAYS*icache_pkg::SETS];

	// Fill writes land in one edge
	always_ff @(posedge clk) begin
		if (wr_i) begin
			mem[wadr_i] <= wdata_i;
		end
	end

	// Synchronous read so the array maps onto block RAM
	// The data lines up with the registered tags one cycle later
	always_ff @(posedge clk) begin
		rdata_o <= mem[rd_adr_i];
	end

endmodule

//--- design/icache_tag_ram.sv
// ====================================================================
// Virtual and physical tag store for one bank, all ways side by side
// Lookup read is registered and snoop read is combinational
// Contents are undefined until a fill and rely on the valid bits
// ====================================================================
`timescale 1ns/1ps

module icache_tag_ram (
	input  logic                                      clk,
	input  logic                                      wr_i,
	input  icache_pkg::way_t                          way_i,
	input  icache_pkg::index_t                        widx_i,
	input  icache_pkg::tag_t                          vtag_i,
	input  icache_pkg::tag_t                          ptag_i,
	input  icache_pkg::index_t                        ridx_i,
	output icache_pkg::tag_t [icache_pkg::WAYS-1:0]  vtags_o,
	input  icache_pkg::index_t                        sidx_i,
	output icache_pkg::tag_t [icache_pkg::WAYS-1:0]  ptags_o
);

	// Virtual tags answer lookups from the fetch unit
	icache_pkg::tag_t vtag_mem [icache_pkg::WAYS][icache_pkg::SETS];

	// Physical tags are only ever compared against snoop addresses
	icache_pkg::tag_t ptag_mem [icache_pkg::WAYS][icache_pkg::SETS];

	// ================================================================
	// Fill write
	// ================================================================

	// Both tags of the filled way are written together
	always_ff @(posedge clk) begin
		if (wr_i) begin
			vtag_mem[way_i][widx_i] <= vtag_i;
			ptag_mem[way_i][widx_i] <= ptag_i;
		end
	end

	// ================================================================
	// Reads
	// ================================================================

	// Lookup read of every way at the requested set
	// Registered to match the line RAM latency
	always_ff @(posedge clk) begin
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			vtags_o[w] <= vtag_mem[w][ridx_i];
		end
	end

	// Snoop read is unregistered so that the bank can clear
	// matching valid bits on the same edge that carries the snoop
	always_comb begin
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			ptags_o[w] = ptag_mem[w][sidx_i];
		end
	end

	// A write with an unknown set would corrupt tags the valid bits still trust
	a_widx_known: assert property (@(posedge clk) wr_i |-> !$isunknown(widx_i));

endmodule

//--- design/icache_hit.sv
// ====================================================================
// Way comparator for one bank
// Expects tags from a one-cycle registered read
// At most one way may hold a given tag in a set
// ====================================================================
`timescale 1ns/1ps

module icache_hit (
	input  logic                                      clk,
	input  logic                                      rst,
	input  icache_pkg::tag_t [icache_pkg::WAYS-1:0]  vtags_i,
	input  icache_pkg::tag_t                          rtag_i,
	input  logic [icache_pkg::WAYS-1:0]               valid_i,
	output logic                                      hit_o,
	output icache_pkg::way_t                          way_o
);

	// Request tag and valid bits delayed to meet the registered tags
	icache_pkg::tag_t rtag_q;
	logic [icache_pkg::WAYS-1:0] valid_q;

	// Per-way tag match qualified by valid
	logic [icache_pkg::WAYS-1:0] match;

	// Valid bits clear on reset so that no hit is reported afterwards
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= valid_i;
		end
	end

	// The tag is only meaningful together with valid_q
	always_ff @(posedge clk) begin
		rtag_q <= rtag_i;
	end

	always_comb begin
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			match[w] = valid_q[w] && (vtags_i[w] == rtag_q);
		end
	end

	// Scan from the top down so the lowest matching way ends up in way_o
	always_comb begin
		hit_o = |match;
		way_o = '0;
		for (int w = icache_pkg::WAYS - 1; w >= 0; w--) begin
			if (match[w]) begin
				way_o = icache_pkg::way_t'(w);
			end
		end
	end

	// Two ways with the same tag means the miss handler refilled a line that hit
	a_one_way: assert property (@(posedge clk) disable iff (rst) $onehot0(match));

endmodule

//--- design/icache_bank.sv
// ====================================================================
// One cache bank: valid bits, tag RAM, way compare and line RAM
// Lookup result appears one cycle after ridx_i and rtag_i
// A lookup of the set being filled on the same edge is undefined
// ====================================================================
`timescale 1ns/1ps

module icache_bank (
	input  logic                 clk,
	input  logic                 rst,
	input  icache_pkg::index_t   ridx_i,
	input  icache_pkg::tag_t     rtag_i,
	input  logic                 fill_i,
	input  icache_pkg::way_t     fill_way_i,
	input  icache_pkg::index_t   fill_idx_i,
	input  icache_pkg::tag_t     fill_vtag_i,
	input  icache_pkg::tag_t     fill_ptag_i,
	input  icache_pkg::line_t    fill_line_i,
	input  icache_pkg::inv_op_t  inv_op_i,
	input  icache_pkg::index_t   inv_idx_i,
	input  logic                 snoop_i,
	input  icache_pkg::index_t   snoop_idx_i,
	input  icache_pkg::tag_t     snoop_tag_i,
	output logic                 hit_o,
	output icache_pkg::line_t    line_o
);

	// One valid bit per way and set
	logic [icache_pkg::WAYS-1:0][icache_pkg::SETS-1:0] valid_q;

	// Valid bits of every way at the lookup set
	logic [icache_pkg::WAYS-1:0] valid_rd;

	// Ways whose physical tag matches the snoop address
	logic [icache_pkg::WAYS-1:0] snoop_hit;

	icache_pkg::tag_t [icache_pkg::WAYS-1:0] vtags;
	icache_pkg::tag_t [icache_pkg::WAYS-1:0] ptags;

	// Line of each way at the lookup set, read in parallel
	icache_pkg::line_t way_lines [icache_pkg::WAYS];

	icache_pkg::way_t hit_way;

	// ================================================================
	// Valid bits
	// ================================================================

	always_comb begin
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			valid_rd[w] = valid_q[w][ridx_i];
			snoop_hit[w] = snoop_i && (ptags[w] == snoop_tag_i);
		end
	end

	// Snoop clears are issued first so that a fill of the same entry
	// in this cycle overrides them
	// Invalidation only acts when the bank sees no fill
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			for (int w = 0; w < icache_pkg::WAYS; w++) begin
				if (snoop_hit[w]) begin
					valid_q[w][snoop_idx_i] <= 1'b0;
				end
			end
			if (fill_i) begin
				valid_q[fill_way_i][fill_idx_i] <= 1'b1;
			end else begin
				case (inv_op_i)
					icache_pkg::INV_LINE: begin
						for (int w = 0; w < icache_pkg::WAYS; w++) begin
							valid_q[w][inv_idx_i] <= 1'b0;
						end
					end
					icache_pkg::INV_ALL: begin
						valid_q <= '0;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// ================================================================
	// Storage and compare
	// ================================================================

	icache_tag_ram i_tag_ram (
		.clk     (clk),
		.wr_i    (fill_i),
		.way_i   (fill_way_i),
		.widx_i  (fill_idx_i),
		.vtag_i  (fill_vtag_i),
		.ptag_i  (fill_ptag_i),
		.ridx_i  (ridx_i),
		.vtags_o (vtags),
		.sidx_i  (snoop_idx_i),
		.ptags_o (ptags)
	);

	icache_hit i_hit (
		.clk     (clk),
		.rst     (rst),
		.vtags_i (vtags),
		.rtag_i  (rtag_i),
		.valid_i (valid_rd),
		.hit_o   (hit_o),
		.way_o   (hit_way)
	);

	// Every copy takes every fill, and each copy reads one fixed way
	// This gives one read port per way without a second cycle
	for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_line_ram
		icache_line_ram i_line_ram (
			.clk      (clk),
			.wr_i     (fill_i),
			.wadr_i   ({fill_way_i, fill_idx_i}),
			.rd_adr_i ({icache_pkg::way_t'(w), ridx_i}),
			.wdata_i  (fill_line_i),
			.rdata_o  (way_lines[w])
		);
	end

	// The hitting way picks its line
	assign line_o = way_lines[hit_way];

	a_inv_op_legal: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(inv_op_i) && inv_op_i inside
		{icache_pkg::INV_NONE, icache_pkg::INV_LINE, icache_pkg::INV_ALL});

endmodule

//--- design/icache.sv
// ====================================================================
// Two-bank instruction cache returning the fetch line and the next line
// One lookup every cycle, results exactly one cycle after ip_i
// Fills come from an outside miss handler that picks the way
// ====================================================================
`timescale 1ns/1ps

module icache (
	input  logic                 clk,
	input  logic                 rst,
	input  icache_pkg::addr_t    ip_i,
	input  logic                 fill_i,
	input  icache_pkg::addr_t    fill_vadr_i,
	input  icache_pkg::addr_t    fill_padr_i,
	input  icache_pkg::way_t     fill_way_i,
	input  icache_pkg::line_t    fill_line_i,
	input  icache_pkg::inv_op_t  inv_op_i,
	input  icache_pkg::addr_t    inv_adr_i,
	input  logic                 snoop_v_i,
	input  icache_pkg::addr_t    snoop_adr_i,
	input  icache_pkg::cid_t     snoop_cid_i,
	output icache_pkg::addr_t    ip_o,
	output icache_pkg::line_t    line_lo_o,
	output icache_pkg::line_t    line_hi_o,
	output logic                 lo_hit_o,
	output logic                 hi_hit_o,
	output logic                 hit_o,
	output icache_pkg::addr_t    miss_adr_o
);

	// Even bank line address, one line on when ip is in an odd line
	logic [icache_pkg::SET_ADR_W-1:0] even_set_adr;

	// Per-bank lookup index and tag, bank 0 even and bank 1 odd
	icache_pkg::index_t bank_ridx [icache_pkg::BANKS];
	icache_pkg::tag_t bank_rtag [icache_pkg::BANKS];

	// Snoop accepted from another requester
	logic snoop_act;

	logic [icache_pkg::BANKS-1:0] bank_hit;
	icache_pkg::line_t bank_line [icache_pkg::BANKS];

	// Lookup address and bank order of the lookup in flight
	icache_pkg::addr_t ip_q;
	logic odd_q;

	// Line numbers of the lo and hi lines
	logic [icache_pkg::ADDR_W-icache_pkg::LOBIT-1:0] lo_line_adr;
	logic [icache_pkg::ADDR_W-icache_pkg::LOBIT-1:0] hi_line_adr;

	// ================================================================
	// Lookup address split
	// ================================================================

	// Adding the bank bit across tag and index wraps set 15 into set 0
	// of the next tag
	assign even_set_adr = ip_i[icache_pkg::ADDR_W-1:icache_pkg::IDX_LO] +
		{{(icache_pkg::SET_ADR_W-1){1'b0}}, ip_i[icache_pkg::LOBIT]};

	always_comb begin
		bank_ridx[0] = even_set_adr[icache_pkg::IDX_W-1:0];
		bank_rtag[0] = even_set_adr[icache_pkg::SET_ADR_W-1:icache_pkg::IDX_W];
		bank_ridx[1] = ip_i[icache_pkg::TAG_LO-1:icache_pkg::IDX_LO];
		bank_rtag[1] = ip_i[icache_pkg::ADDR_W-1:icache_pkg::TAG_LO];
	end

	// Own snoops are echoes of this cache's traffic
	assign snoop_act = snoop_v_i && (snoop_cid_i != icache_pkg::CID);

	// ================================================================
	// Banks
	// ================================================================

	for (genvar b = 0; b < icache_pkg::BANKS; b++) begin : g_bank
		logic fill_b;
		icache_pkg::inv_op_t inv_op_b;

		// Fill goes only to the bank its virtual address selects
		assign fill_b = fill_i && (fill_vadr_i[icache_pkg::LOBIT] == 1'(b));

		// A line invalidation is dropped by the other bank
		// INV_ALL reaches both
		assign inv_op_b = (inv_op_i == icache_pkg::INV_LINE &&
			inv_adr_i[icache_pkg::LOBIT] != 1'(b)) ? icache_pkg::INV_NONE : inv_op_i;

		// Snoops go to both banks since the snoop bank bit is physical
		icache_bank i_bank (
			.clk         (clk),
			.rst         (rst),
			.ridx_i      (bank_ridx[b]),
			.rtag_i      (bank_rtag[b]),
			.fill_i      (fill_b),
			.fill_way_i  (fill_way_i),
			.fill_idx_i  (fill_vadr_i[icache_pkg::TAG_LO-1:icache_pkg::IDX_LO]),
			.fill_vtag_i (fill_vadr_i[icache_pkg::ADDR_W-1:icache_pkg::TAG_LO]),
			.fill_ptag_i (fill_padr_i[icache_pkg::ADDR_W-1:icache_pkg::TAG_LO]),
			.fill_line_i (fill_line_i),
			.inv_op_i    (inv_op_b),
			.inv_idx_i   (inv_adr_i[icache_pkg::TAG_LO-1:icache_pkg::IDX_LO]),
			.snoop_i     (snoop_act),
			.snoop_idx_i (snoop_adr_i[icache_pkg::TAG_LO-1:icache_pkg::IDX_LO]),
			.snoop_tag_i (snoop_adr_i[icache_pkg::ADDR_W-1:icache_pkg::TAG_LO]),
			.hit_o       (bank_hit[b]),
			.line_o      (bank_line[b])
		);
	end

	// ================================================================
	// Output ordering and miss address
	// ================================================================

	always_ff @(posedge clk) begin
		ip_q <= ip_i;
	end

	// The bank order bit drives the output muxes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			odd_q <= 1'b0;
		end else begin
			odd_q <= ip_i[icache_pkg::LOBIT];
		end
	end

	assign ip_o = ip_q;

	// Odd ip puts the odd line first and the next even line second
	always_comb begin
		lo_hit_o = odd_q ? bank_hit[1] : bank_hit[0];
		hi_hit_o = odd_q ? bank_hit[0] : bank_hit[1];
		line_lo_o = odd_q ? bank_line[1] : bank_line[0];
		line_hi_o = odd_q ? bank_line[0] : bank_line[1];
		hit_o = lo_hit_o && hi_hit_o;
	end

	assign lo_line_adr = ip_q[icache_pkg::ADDR_W-1:icache_pkg::LOBIT];
	assign hi_line_adr = lo_line_adr + 1'b1;

	// The lo line is requested first, then the hi line
	always_comb begin
		if (!lo_hit_o) begin
			miss_adr_o = {lo_line_adr, {icache_pkg::LOBIT{1'b0}}};
		end else if (!hi_hit_o) begin
			miss_adr_o = {hi_line_adr, {icache_pkg::LOBIT{1'b0}}};
		end else begin
			miss_adr_o = '0;
		end
	end

	// A lookup of the set that a fill writes on the same edge reads stale tags and data
	a_fill_apart: assert property (@(posedge clk) disable iff (rst)
		fill_i |-> bank_ridx[fill_vadr_i[icache_pkg::LOBIT]] !=
		fill_vadr_i[icache_pkg::TAG_LO-1:icache_pkg::IDX_LO]);

endmodule

//--- tb/icache_tb.sv
// ======================================================================
// Self-checking testbench for the two-bank instruction cache
// It acts as the miss handler and never puts one tag into two ways of a set
// Line data is a fixed function of the line address, so no data store is kept
// ======================================================================
`timescale 1ns/1ps

module icache_tb;

	localparam int RAND_CYCLES = 400;
	localparam int DIRECTED_CYCLES = 64;
	localparam int MAX_CYCLES = DIRECTED_CYCLES + RAND_CYCLES + 100;

	// Physical addresses differ from virtual ones in one tag bit only
	localparam icache_pkg::addr_t PMAP = 32'h4000_0000;

	// Everything the reference expects for one lookup
	typedef struct packed {
		icache_pkg::line_t lo;
		icache_pkg::line_t hi;
		logic lo_hit;
		logic hi_hit;
		icache_pkg::addr_t miss;
	} expect_t;

	logic clk = 1'b0;
	logic rst;
	icache_pkg::addr_t ip, fill_vadr, fill_padr, inv_adr, snoop_adr;
	logic fill, snoop_v;
	icache_pkg::way_t fill_way;
	icache_pkg::line_t fill_line;
	icache_pkg::inv_op_t inv_op;
	icache_pkg::cid_t snoop_cid;
	icache_pkg::addr_t ip_o, miss_adr_o;
	icache_pkg::line_t line_lo_o, line_hi_o;
	logic lo_hit_o, hi_hit_o, hit_o;

	// Reference state per bank, way and set
	logic mv [icache_pkg::BANKS][icache_pkg::WAYS][icache_pkg::SETS];
	icache_pkg::tag_t mvt [icache_pkg::BANKS][icache_pkg::WAYS][icache_pkg::SETS];
	icache_pkg::tag_t mpt [icache_pkg::BANKS][icache_pkg::WAYS][icache_pkg::SETS];

	// Lookup just driven, and the one the DUT is answering now
	expect_t drv_exp, flight_exp;
	icache_pkg::addr_t drv_ip, flight_ip;
	logic drv_v = 1'b0;
	logic flight_v = 1'b0;
	string drv_name, flight_name, cur_test;

	logic [31:0] rnd, r_fill, r_misc;
	icache_pkg::addr_t r_ip, r_fv, r_ia, r_sa;
	logic r_f, r_sv;
	icache_pkg::way_t r_fw;
	icache_pkg::inv_op_t r_op;
	icache_pkg::cid_t r_sc;

	icache i_dut (
		.clk         (clk),
		.rst         (rst),
		.ip_i        (ip),
		.fill_i      (fill),
		.fill_vadr_i (fill_vadr),
		.fill_padr_i (fill_padr),
		.fill_way_i  (fill_way),
		.fill_line_i (fill_line),
		.inv_op_i    (inv_op),
		.inv_adr_i   (inv_adr),
		.snoop_v_i   (snoop_v),
		.snoop_adr_i (snoop_adr),
		.snoop_cid_i (snoop_cid),
		.ip_o        (ip_o),
		.line_lo_o   (line_lo_o),
		.line_hi_o   (line_hi_o),
		.lo_hit_o    (lo_hit_o),
		.hi_hit_o    (hi_hit_o),
		.hit_o       (hit_o),
		.miss_adr_o  (miss_adr_o)
	);

	always #4 clk = ~clk;

	// ==================================================================
	// Reference model
	// ==================================================================

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Every word of the line depends on the whole line address
	function automatic icache_pkg::line_t line_data(input icache_pkg::addr_t a);
		icache_pkg::addr_t la;
		la = {a[31:4], 4'h0};
		return {~la, la + 32'h1357_9bdf, {la[15:0], la[31:16]}, la ^ 32'h0f0f_3c3c};
	endfunction

	// A line number holds the bank in bit 0, the set above it and then the tag
	function automatic logic line_present(input logic [27:0] la);
		logic found;
		found = 1'b0;
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (mv[la[0]][w][la[4:1]] && mvt[la[0]][w][la[4:1]] == la[27:5]) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	// lo is the line holding ip and hi the line after it, whatever the bank
	function automatic expect_t ref_lookup(input icache_pkg::addr_t a);
		logic [27:0] lo_la, hi_la;
		expect_t r;
		lo_la = a[31:4];
		hi_la = lo_la + 28'd1;
		r.lo_hit = line_present(lo_la);
		r.hi_hit = line_present(hi_la);
		r.lo = line_data({lo_la, 4'h0});
		r.hi = line_data({hi_la, 4'h0});
		if (!r.lo_hit) begin
			r.miss = {lo_la, 4'h0};
		end else if (!r.hi_hit) begin
			r.miss = {hi_la, 4'h0};
		end else begin
			r.miss = '0;
		end
		return r;
	endfunction

	// True when a fill would hit the set that the lookup reads in the fill's bank
	function automatic logic collides(input icache_pkg::addr_t a, input icache_pkg::addr_t fv);
		icache_pkg::index_t even_idx;
		even_idx = a[8:5] + icache_pkg::index_t'(a[4]);
		if (fv[4]) begin
			return fv[8:5] == a[8:5];
		end
		return fv[8:5] == even_idx;
	endfunction

	// Reuse the way that already holds the tag, else take the random way
	function automatic icache_pkg::way_t choose_way(input icache_pkg::addr_t fv, input logic rbit);
		icache_pkg::way_t way;
		way = rbit;
		for (int w = 0; w < icache_pkg::WAYS; w++) begin
			if (mv[fv[4]][w][fv[8:5]] && mvt[fv[4]][w][fv[8:5]] == fv[31:9]) begin
				way = icache_pkg::way_t'(w);
			end
		end
		return way;
	endfunction

	// ==================================================================
	// Stimulus
	// ==================================================================

	// One cycle of input, and the model update that the next edge applies
	task automatic tick(input icache_pkg::addr_t a, input logic f, input icache_pkg::addr_t fv,
		input icache_pkg::way_t fw, input icache_pkg::inv_op_t op, input icache_pkg::addr_t ia,
		input logic sv, input icache_pkg::addr_t sa, input icache_pkg::cid_t sc);
		icache_pkg::addr_t padr;
		@(posedge clk);
		#1;
		padr = fv ^ PMAP;
		ip = a;
		fill = f;
		fill_vadr = fv;
		fill_padr = padr;
		fill_way = fw;
		fill_line = line_data(fv);
		inv_op = op;
		inv_adr = ia;
		snoop_v = sv;
		snoop_adr = sa;
		snoop_cid = sc;
		// The lookup sees the state from before this cycle's updates
		drv_exp = ref_lookup(a);
		drv_ip = a;
		drv_name = cur_test;
		drv_v = 1'b1;
		// Snoop clears first, a fill then wins for its own entry
		if (sv && sc != icache_pkg::CID) begin
			for (int b = 0; b < icache_pkg::BANKS; b++) begin
				for (int w = 0; w < icache_pkg::WAYS; w++) begin
					if (mpt[b][w][sa[8:5]] == sa[31:9]) begin
						mv[b][w][sa[8:5]] = 1'b0;
					end
				end
			end
		end
		if (f) begin
			mvt[fv[4]][fw][fv[8:5]] = fv[31:9];
			mpt[fv[4]][fw][fv[8:5]] = padr[31:9];
			mv[fv[4]][fw][fv[8:5]] = 1'b1;
		end
		// A bank taking a fill drops the invalidation
		for (int b = 0; b < icache_pkg::BANKS; b++) begin
			if (!(f && int'(fv[4]) == b)) begin
				for (int w = 0; w < icache_pkg::WAYS; w++) begin
					for (int s = 0; s < icache_pkg::SETS; s++) begin
						if (op == icache_pkg::INV_ALL ||
							(op == icache_pkg::INV_LINE && int'(ia[4]) == b && int'(ia[8:5]) == s)) begin
							mv[b][w][s] = 1'b0;
						end
					end
				end
			end
		end
	endtask

	task automatic look(input icache_pkg::addr_t a);
		tick(a, 1'b0, '0, '0, icache_pkg::INV_NONE, '0, 1'b0, '0, '0);
	endtask

	// Flipping address bit 8 keeps the lookup away from the filled set
	task automatic fill_at(input icache_pkg::addr_t fv, input icache_pkg::way_t fw);
		tick(fv ^ 32'h100, 1'b1, fv, fw, icache_pkg::INV_NONE, '0, 1'b0, '0, '0);
	endtask

	task automatic inv_at(input icache_pkg::inv_op_t op, input icache_pkg::addr_t ia);
		tick(ia ^ 32'h100, 1'b0, '0, '0, op, ia, 1'b0, '0, '0);
	endtask

	task automatic snoop_at(input icache_pkg::addr_t sa, input logic sv, input icache_pkg::cid_t sc);
		tick(32'h0, 1'b0, '0, '0, icache_pkg::INV_NONE, '0, sv, sa, sc);
	endtask

	initial begin
		rst = 1'b1;
		ip = '0;
		fill = 1'b0;
		fill_vadr = '0;
		fill_padr = '0;
		fill_way = '0;
		fill_line = '0;
		inv_op = icache_pkg::INV_NONE;
		inv_adr = '0;
		snoop_v = 1'b0;
		snoop_adr = '0;
		snoop_cid = '0;
		rnd = 32'hb6be;
		for (int b = 0; b < icache_pkg::BANKS; b++) begin
			for (int w = 0; w < icache_pkg::WAYS; w++) begin
				for (int s = 0; s < icache_pkg::SETS; s++) begin
					mv[b][w][s] = 1'b0;
					mvt[b][w][s] = '0;
					mpt[b][w][s] = '0;
				end
			end
		end
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;

		cur_test = "reset";
		look(32'h0000_1000);
		look(32'h0000_1014);
		look(32'h0000_11f8);
		look(32'h0000_2040);

		// Even pair at set 2, then an odd line at set 15 whose next line wraps
		cur_test = "pairs";
		fill_at(32'h0000_2040, 1'b0);
		fill_at(32'h0000_2050, 1'b1);
		look(32'h0000_2044);
		look(32'h0000_2054);
		fill_at(32'h0000_21f0, 1'b0);
		look(32'h0000_21f8);
		fill_at(32'h0000_2200, 1'b1);
		look(32'h0000_21f0);
		fill_at(32'h0000_2670, 1'b0);
		look(32'h0000_2660);
		fill_at(32'h0000_2660, 1'b1);
		look(32'h0000_2668);

		cur_test = "ways";
		fill_at(32'h0000_3080, 1'b0);
		fill_at(32'h0000_5080, 1'b1);
		look(32'h0000_3080);
		look(32'h0000_5084);
		fill_at(32'h0000_7080, 1'b0);
		look(32'h0000_3080);
		look(32'h0000_5080);
		look(32'h0000_7088);

		cur_test = "inval";
		inv_at(icache_pkg::INV_LINE, 32'h0000_5080);
		look(32'h0000_5080);
		look(32'h0000_7080);
		look(32'h0000_2044);
		inv_at(icache_pkg::INV_ALL, 32'h0);
		look(32'h0000_2044);
		look(32'h0000_21f0);

		// Both banks hold the same physical tag at set 8, so one snoop clears both
		cur_test = "snoop";
		fill_at(32'h0000_6100, 1'b1);
		fill_at(32'h0000_6110, 1'b0);
		look(32'h0000_6104);
		snoop_at(32'h0000_6100 ^ PMAP, 1'b1, icache_pkg::CID);
		look(32'h0000_6104);
		snoop_at(32'h0000_6100 ^ PMAP, 1'b0, 6'd5);
		look(32'h0000_6104);
		snoop_at(32'h0000_6100 ^ PMAP, 1'b1, 6'd5);
		look(32'h0000_6104);
		look(32'h0000_6114);

		// A small window of tags keeps hits, evictions and snoop matches frequent
		cur_test = "random";
		for (int i = 0; i < RAND_CYCLES; i++) begin
			rnd = xorshift(rnd);
			r_ip = 32'h0040_0000 | (rnd & 32'h0000_07ff);
			rnd = xorshift(rnd);
			r_fill = rnd;
			rnd = xorshift(rnd);
			r_misc = rnd;
			r_fv = 32'h0040_0000 | ((r_fill >> 4) & 32'h0000_07f0);
			r_f = r_fill[0] && !collides(r_ip, r_fv);
			r_fw = choose_way(r_fv, r_fill[31]);
			r_op = icache_pkg::INV_NONE;
			if (r_misc[27:24] == 4'h0) begin
				r_op = icache_pkg::INV_LINE;
			end else if (r_misc[27:20] == 8'h1f) begin
				r_op = icache_pkg::INV_ALL;
			end
			r_ia = 32'h0040_0000 | ((r_misc >> 8) & 32'h0000_07f0);
			r_sv = r_misc[2:0] == 3'd0;
			r_sa = (32'h0040_0000 | ((r_misc >> 12) & 32'h0000_07f0)) ^ PMAP;
			r_sc = r_misc[3] ? icache_pkg::CID : 6'd9;
			tick(r_ip, r_f, r_fv, r_fw, r_op, r_ia, r_sv, r_sa, r_sc);
		end

		// Let the last lookup reach the compare process before finishing
		@(posedge clk);
		#1;
		drv_v = 1'b0;
		fill = 1'b0;
		inv_op = icache_pkg::INV_NONE;
		snoop_v = 1'b0;
		repeat (2) @(negedge clk);
		$display("Result: PASSED");
		$finish;
	end

	// ==================================================================
	// Checking
	// ==================================================================

	task automatic check_line(input string name, input icache_pkg::line_t exp,
		input icache_pkg::line_t act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "line mismatch");
		end
	endtask

	task automatic check_addr(input string name, input icache_pkg::addr_t exp,
		input icache_pkg::addr_t act);
		if (exp !== act) begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAIL %s: expected %b, actual %b", name, exp, act);
			$display("Result: FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	// The edge that samples a lookup moves it in flight
	always @(posedge clk) begin
		flight_v <= drv_v;
		flight_exp <= drv_exp;
		flight_ip <= drv_ip;
		flight_name <= drv_name;
	end

	// Outputs are settled half a cycle after that edge
	always @(negedge clk) begin
		if (flight_v) begin
			check_addr({flight_name, " ip_o"}, flight_ip, ip_o);
			check_flag({flight_name, " lo_hit_o"}, flight_exp.lo_hit, lo_hit_o);
			check_flag({flight_name, " hi_hit_o"}, flight_exp.hi_hit, hi_hit_o);
			check_flag({flight_name, " hit_o"}, flight_exp.lo_hit && flight_exp.hi_hit, hit_o);
			check_addr({flight_name, " miss_adr_o"}, flight_exp.miss, miss_adr_o);
			if (flight_exp.lo_hit) begin
				check_line({flight_name, " line_lo_o"}, flight_exp.lo, line_lo_o);
			end
			if (flight_exp.hi_hit) begin
				check_line({flight_name, " line_hi_o"}, flight_exp.hi, line_hi_o);
			end
		end
	end

	initial begin
		#(MAX_CYCLES * 8);
		$display("ERROR: the run hung, watchdog expired after %0d cycles", MAX_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "watchdog timeout");
	end

endmodule

//--- compile.f
design/icache_pkg.sv
design/icache_line_ram.sv
design/icache_tag_ram.sv
design/icache_hit.sv
design/icache_bank.sv
design/icache.sv
tb/icache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module icache_tb -f compile.f

out=$(./obj_dir/Vicache_tb 2>&1) || true
echo "$out"

if grep -q "Result: PASSED" <<< "$out"; then
	exit 0
else
	exit 1
fi
